/* Makefile */
TOP       ?= mem_stage_tb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
OBJ_DIR   ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator from build.f and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: TOP=$(TOP) VERILATOR=$(VERILATOR) FLAGS='$(FLAGS)'"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
rtl/mem_stage_pkg.sv
rtl/ex_mem.sv
rtl/mem_ctrl_fsm.sv
rtl/mem_wait_timer.sv
rtl/data_mem.sv
rtl/wb_select.sv
rtl/mem_stage_top.sv
tb/mem_stage_checker.sv
tb/mem_stage_tb.sv

/* rtl/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              go,       // access strobe
   input  logic                              wr_en,
   input  logic [mem_stage_pkg::data_w-1:0]  addr,
   input  logic [mem_stage_pkg::data_w-1:0]  wr_data,
   output logic [mem_stage_pkg::data_w-1:0]  rd_data
);

   import mem_stage_pkg::*;

   localparam int depth = 1 << mem_addr_w;

   logic [data_w-1:0]     mem [depth];
   logic [mem_addr_w-1:0] word_addr;

   assign word_addr = addr[mem_addr_w-1:0];   // word addressed, upper bits ignored

   // contents start at zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;
         end
      end else if (go && wr_en) begin
         mem[word_addr] <= wr_data;
      end
   end

   // read data stays valid until the next load
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_data <= '0;
      end else if (go && !wr_en) begin
         rd_data <= mem[word_addr];
      end
   end

endmodule

`default_nettype wire

/* rtl/ex_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_mem (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   control_stall_n,  // low on external hazard
   input  logic                                   mem_busy,
   input  logic                                   in_stall_n,       // low means no instruction
   input  logic [mem_stage_pkg::data_w-1:0]       in_alu_out,
   input  logic [mem_stage_pkg::data_w-1:0]       in_rd_data_2,
   input  logic [mem_stage_pkg::data_w-1:0]       in_sext_imm,
   input  logic                                   in_alu_zero,
   input  logic                                   in_alu_ltz,
   input  logic                                   in_alu_lteq,
   input  logic                                   in_alu_ofl,
   input  logic [mem_stage_pkg::set_sel_w-1:0]    in_set_sel,
   input  logic                                   in_mem_en,
   input  logic                                   in_mem_wr_en,
   input  logic [mem_stage_pkg::reg_addr_w-1:0]   in_wr_reg,
   input  logic [mem_stage_pkg::wb_sel_w-1:0]     in_wr_sel,
   output logic                                   stall_n,
   output logic                                   out_fresh,
   output logic [mem_stage_pkg::data_w-1:0]       out_alu_out,
   output logic [mem_stage_pkg::data_w-1:0]       out_rd_data_2,
   output logic [mem_stage_pkg::data_w-1:0]       out_sext_imm,
   output logic                                   out_alu_zero,
   output logic                                   out_alu_ltz,
   output logic                                   out_alu_lteq,
   output logic                                   out_alu_ofl,
   output logic [mem_stage_pkg::set_sel_w-1:0]    out_set_sel,
   output logic                                   out_mem_en,
   output logic                                   out_mem_wr_en,
   output logic [mem_stage_pkg::reg_addr_w-1:0]   out_wr_reg,
   output logic [mem_stage_pkg::wb_sel_w-1:0]     out_wr_sel
);

   import mem_stage_pkg::*;

   // the stage takes a new entry only when neither hold is active
   assign stall_n = control_stall_n & ~mem_busy;

   // control fields, a bubble clears every enable
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_fresh     <= 1'b0;
         out_mem_en    <= 1'b0;
         out_mem_wr_en <= 1'b0;
         out_wr_sel    <= wb_none;
      end else if (stall_n) begin
         if (in_stall_n) begin
            out_fresh     <= 1'b1;
            out_mem_en    <= in_mem_en;
            out_mem_wr_en <= in_mem_wr_en;
            out_wr_sel    <= in_wr_sel;
         end else begin
            out_fresh     <= 1'b0;            // bubble
            out_mem_en    <= 1'b0;
            out_mem_wr_en <= 1'b0;
            out_wr_sel    <= wb_none;
         end
      end else begin
         out_fresh <= 1'b0;                   // held entry is no longer new
      end
   end

   // payload fields, don't care under a bubble
   always_ff @(posedge clk) begin
      if (stall_n) begin
         out_alu_out   <= in_alu_out;
         out_rd_data_2 <= in_rd_data_2;
         out_sext_imm  <= in_sext_imm;
         out_alu_zero  <= in_alu_zero;
         out_alu_ltz   <= in_alu_ltz;
         out_alu_lteq  <= in_alu_lteq;
         out_alu_ofl   <= in_alu_ofl;
         out_set_sel   <= in_set_sel;
         out_wr_reg    <= in_wr_reg;
      end
   end

endmodule

`default_nettype wire

/* rtl/mem_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_fsm (
   input  logic clk,
   input  logic rst_n,
   input  logic fresh,       // entry was captured at the last edge
   input  logic mem_en,
   input  logic expired,     // wait timer done
   output logic mem_busy,    // holds the stage
   output logic timer_load,
   output logic mem_go,      // one-cycle memory strobe
   output logic mem_wb       // load data is valid for writeback
);

   import mem_stage_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nxt;
   logic        start;

   // only a new memory instruction starts an access,
   // so a held entry never starts a second one
   assign start = fresh & mem_en;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         idle: begin
            if (start) begin
               state_nxt = access;
            end
         end
         access: begin
            if (expired) begin
               state_nxt = done;
            end
         end
         done: begin
            state_nxt = idle;            // writeback takes one cycle
         end
         default: begin
            state_nxt = idle;
         end
      endcase
   end

   // busy must already be high in the capture cycle, or the
   // register would take the next entry over the access
   assign timer_load = (state == idle) & start;
   assign mem_busy   = timer_load | (state == access);
   assign mem_go     = (state == access) & expired;
   assign mem_wb     = (state == done);

endmodule

`default_nettype wire

/* rtl/mem_stage_pkg.sv */
`default_nettype none

package mem_stage_pkg;

   // datapath and register file sizes
   localparam int data_w     = 16;
   localparam int reg_addr_w = 3;
   localparam int wb_sel_w   = 3;
   localparam int set_sel_w  = 2;

   // data memory geometry and timing
   localparam int mem_addr_w  = 8;   // 256 words
   localparam int mem_latency = 3;   // cycles per access
   localparam int timer_w     = 2;   // must hold mem_latency-1

   // writeback source select
   localparam logic [wb_sel_w-1:0] wb_none = 3'd0;  // no register write
   localparam logic [wb_sel_w-1:0] wb_alu  = 3'd1;
   localparam logic [wb_sel_w-1:0] wb_mem  = 3'd2;
   localparam logic [wb_sel_w-1:0] wb_set  = 3'd3;
   localparam logic [wb_sel_w-1:0] wb_imm  = 3'd4;

   // set-condition flag select
   localparam logic [set_sel_w-1:0] set_eq  = 2'd0;  // zero flag
   localparam logic [set_sel_w-1:0] set_lt  = 2'd1;  // less than zero
   localparam logic [set_sel_w-1:0] set_le  = 2'd2;  // less or equal
   localparam logic [set_sel_w-1:0] set_ofl = 2'd3;  // overflow

   // memory access sequencer states
   typedef enum logic [1:0] {
      idle   = 2'd0,
      access = 2'd1,
      done   = 2'd2
   } ctrl_state_t;

endpackage

`default_nettype wire

/* rtl/mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic [mem_stage_pkg::data_w-1:0]      in_alu_out,
   input  logic [mem_stage_pkg::data_w-1:0]      in_rd_data_2,
   input  logic [mem_stage_pkg::data_w-1:0]      in_sext_imm,
   input  logic                                  in_alu_zero,
   input  logic                                  in_alu_ltz,
   input  logic                                  in_alu_lteq,
   input  logic                                  in_alu_ofl,
   input  logic [mem_stage_pkg::set_sel_w-1:0]   in_set_sel,
   input  logic                                  in_mem_en,
   input  logic                                  in_mem_wr_en,
   input  logic [mem_stage_pkg::reg_addr_w-1:0]  in_wr_reg,
   input  logic [mem_stage_pkg::wb_sel_w-1:0]    in_wr_sel,
   input  logic                                  in_stall_n,
   input  logic                                  control_stall_n,
   output logic                                  stall_n,
   output logic                                  wb_en,
   output logic [mem_stage_pkg::reg_addr_w-1:0]  wb_reg,
   output logic [mem_stage_pkg::data_w-1:0]      wb_data
);

   import mem_stage_pkg::*;

   // registered execute-stage fields
   logic                  fresh;
   logic [data_w-1:0]     alu_out;
   logic [data_w-1:0]     rd_data_2;
   logic [data_w-1:0]     sext_imm;
   logic                  alu_zero;
   logic                  alu_ltz;
   logic                  alu_lteq;
   logic                  alu_ofl;
   logic [set_sel_w-1:0]  set_sel;
   logic                  mem_en;
   logic                  mem_wr_en;
   logic [reg_addr_w-1:0] wr_reg;
   logic [wb_sel_w-1:0]   wr_sel;

   logic                  mem_busy;
   logic                  timer_load;
   logic                  expired;
   logic                  mem_go;
   logic                  mem_wb;
   logic [data_w-1:0]     mem_data;

   ex_mem u_ex_mem (
      .clk(clk), .rst_n(rst_n), .control_stall_n(control_stall_n), .mem_busy(mem_busy),
      .in_stall_n(in_stall_n), .in_alu_out(in_alu_out), .in_rd_data_2(in_rd_data_2),
      .in_sext_imm(in_sext_imm), .in_alu_zero(in_alu_zero), .in_alu_ltz(in_alu_ltz),
      .in_alu_lteq(in_alu_lteq), .in_alu_ofl(in_alu_ofl), .in_set_sel(in_set_sel),
      .in_mem_en(in_mem_en), .in_mem_wr_en(in_mem_wr_en), .in_wr_reg(in_wr_reg),
      .in_wr_sel(in_wr_sel), .stall_n(stall_n), .out_fresh(fresh),
      .out_alu_out(alu_out), .out_rd_data_2(rd_data_2), .out_sext_imm(sext_imm),
      .out_alu_zero(alu_zero), .out_alu_ltz(alu_ltz), .out_alu_lteq(alu_lteq),
      .out_alu_ofl(alu_ofl), .out_set_sel(set_sel), .out_mem_en(mem_en),
      .out_mem_wr_en(mem_wr_en), .out_wr_reg(wr_reg), .out_wr_sel(wr_sel)
   );

   mem_ctrl_fsm u_ctrl (
      .clk(clk), .rst_n(rst_n), .fresh(fresh), .mem_en(mem_en), .expired(expired),
      .mem_busy(mem_busy), .timer_load(timer_load), .mem_go(mem_go), .mem_wb(mem_wb)
   );

   mem_wait_timer u_timer (.clk(clk), .rst_n(rst_n), .load(timer_load), .expired(expired));

   // address from the ALU, store data from the second register read port
   data_mem u_dmem (
      .clk(clk), .rst_n(rst_n), .go(mem_go), .wr_en(mem_wr_en),
      .addr(alu_out), .wr_data(rd_data_2), .rd_data(mem_data)
   );

   wb_select u_wb (
      .fresh(fresh), .mem_en(mem_en), .mem_wb(mem_wb), .wr_sel(wr_sel), .wr_reg(wr_reg),
      .alu_out(alu_out), .mem_data(mem_data), .sext_imm(sext_imm), .set_sel(set_sel),
      .alu_zero(alu_zero), .alu_ltz(alu_ltz), .alu_lteq(alu_lteq), .alu_ofl(alu_ofl),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
   );

endmodule

`default_nettype wire

/* rtl/mem_wait_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wait_timer (
   input  logic clk,
   input  logic rst_n,
   input  logic load,
   output logic expired
);

   import mem_stage_pkg::*;

   logic [timer_w-1:0] count;
   logic               running;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count   <= '0;
         running <= 1'b0;
      end else if (load) begin
         count   <= timer_w'(mem_latency - 1);
         running <= 1'b1;
      end else if (running) begin
         if (count == '0) begin
            running <= 1'b0;            // back to idle after the pulse
         end else begin
            count <= count - 1'b1;
         end
      end
   end

   // one pulse, on the last cycle of the access
   assign expired = running & (count == '0);

endmodule

`default_nettype wire

/* rtl/wb_select.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_select (
   input  logic                                  fresh,
   input  logic                                  mem_en,
   input  logic                                  mem_wb,    // load data ready
   input  logic [mem_stage_pkg::wb_sel_w-1:0]    wr_sel,
   input  logic [mem_stage_pkg::reg_addr_w-1:0]  wr_reg,
   input  logic [mem_stage_pkg::data_w-1:0]      alu_out,
   input  logic [mem_stage_pkg::data_w-1:0]      mem_data,
   input  logic [mem_stage_pkg::data_w-1:0]      sext_imm,
   input  logic [mem_stage_pkg::set_sel_w-1:0]   set_sel,
   input  logic                                  alu_zero,
   input  logic                                  alu_ltz,
   input  logic                                  alu_lteq,
   input  logic                                  alu_ofl,
   output logic                                  wb_en,
   output logic [mem_stage_pkg::reg_addr_w-1:0]  wb_reg,
   output logic [mem_stage_pkg::data_w-1:0]      wb_data
);

   import mem_stage_pkg::*;

   logic set_bit;

   always_comb begin
      case (set_sel)
         set_eq:  set_bit = alu_zero;
         set_lt:  set_bit = alu_ltz;
         set_le:  set_bit = alu_lteq;
         default: set_bit = alu_ofl;    // set_ofl
      endcase
   end

   always_comb begin
      case (wr_sel)
         wb_alu:  wb_data = alu_out;
         wb_mem:  wb_data = mem_data;
         wb_set:  wb_data = {{(data_w-1){1'b0}}, set_bit};
         wb_imm:  wb_data = sext_imm;
         default: wb_data = '0;
      endcase
   end

   // non-memory ops write once on the fresh cycle,
   // memory ops wait for the controller's done state
   assign wb_en  = (wr_sel != wb_none) & ((fresh & ~mem_en) | mem_wb);
   assign wb_reg = wr_reg;

endmodule

`default_nettype wire

/* tb/mem_stage_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_checker (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  wb_en,
   input  logic [mem_stage_pkg::reg_addr_w-1:0]  wb_reg,
   input  logic [mem_stage_pkg::data_w-1:0]      wb_data
);

   import mem_stage_pkg::*;

   // expected writebacks in program order
   logic [reg_addr_w-1:0] exp_reg_q[$];
   logic [data_w-1:0]     exp_data_q[$];

   int mismatch_count   = 0;
   int unexpected_count = 0;

   task automatic expect_wb(input logic [reg_addr_w-1:0] r, input logic [data_w-1:0] d);
      exp_reg_q.push_back(r);
      exp_data_q.push_back(d);
   endtask

   function automatic int pending();
      return exp_reg_q.size();
   endfunction

   // writeback outputs are settled by the falling edge
   always @(negedge clk) begin : compare
      logic [reg_addr_w-1:0] r;
      logic [data_w-1:0]     d;
      if (rst_n && wb_en) begin
         if (exp_reg_q.size() == 0) begin
            unexpected_count++;
            $display("unexpected writeback of %h to r%0d at %0t ns, no instruction was owed one",
                     wb_data, wb_reg, $time);
         end else begin
            r = exp_reg_q.pop_front();
            d = exp_data_q.pop_front();
            if (wb_reg !== r || wb_data !== d) begin
               mismatch_count++;
               $display("mismatch at %0t ns: expected r%0d = %h, got r%0d = %h",
                        $time, r, d, wb_reg, wb_data);
            end
         end
      end
   end

endmodule

`default_nettype wire

/* tb/mem_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

   import mem_stage_pkg::*;

   localparam int clk_period = 40;

   typedef enum logic [2:0] {k_alu, k_set, k_imm, k_load, k_store, k_bubble} kind_t;

   typedef struct packed {
      kind_t                 kind;
      logic [data_w-1:0]     val;         // alu result or memory address
      logic [data_w-1:0]     store_data;
      logic [data_w-1:0]     imm;
      logic [3:0]            flags;       // zero, ltz, lteq, ofl
      logic [set_sel_w-1:0]  set_sel;
      logic [reg_addr_w-1:0] wr_reg;
      logic [wb_sel_w-1:0]   wr_sel;
      int                    stalls;      // external hold cycles before the entry
   } step_t;

   logic                  clk;
   logic                  rst_n;
   logic [data_w-1:0]     in_alu_out;
   logic [data_w-1:0]     in_rd_data_2;
   logic [data_w-1:0]     in_sext_imm;
   logic                  in_alu_zero;
   logic                  in_alu_ltz;
   logic                  in_alu_lteq;
   logic                  in_alu_ofl;
   logic [set_sel_w-1:0]  in_set_sel;
   logic                  in_mem_en;
   logic                  in_mem_wr_en;
   logic [reg_addr_w-1:0] in_wr_reg;
   logic [wb_sel_w-1:0]   in_wr_sel;
   logic                  in_stall_n;
   logic                  control_stall_n;
   logic                  stall_n;
   logic                  wb_en;
   logic [reg_addr_w-1:0] wb_reg;
   logic [data_w-1:0]     wb_data;

   step_t             steps[$];
   logic [data_w-1:0] model_mem [1 << mem_addr_w];
   int                timing_errors = 0;
   int                max_stalls    = 0;
   int                limit_ns      = 0;
   bit                table_ready   = 1'b0;

   mem_stage_top uut (
      .clk(clk), .rst_n(rst_n), .in_alu_out(in_alu_out), .in_rd_data_2(in_rd_data_2),
      .in_sext_imm(in_sext_imm), .in_alu_zero(in_alu_zero), .in_alu_ltz(in_alu_ltz),
      .in_alu_lteq(in_alu_lteq), .in_alu_ofl(in_alu_ofl), .in_set_sel(in_set_sel),
      .in_mem_en(in_mem_en), .in_mem_wr_en(in_mem_wr_en), .in_wr_reg(in_wr_reg),
      .in_wr_sel(in_wr_sel), .in_stall_n(in_stall_n), .control_stall_n(control_stall_n),
      .stall_n(stall_n), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
   );

   mem_stage_checker chk (
      .clk(clk), .rst_n(rst_n), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic add_step(input kind_t kind, input logic [data_w-1:0] val,
                           input logic [data_w-1:0] imm, input logic [3:0] flags,
                           input logic [set_sel_w-1:0] set_sel,
                           input logic [reg_addr_w-1:0] wr_reg,
                           input logic [wb_sel_w-1:0] wr_sel, input int stalls);
      step_t s;
      s.kind       = kind;
      s.val        = val;
      s.store_data = 16'($urandom);    // only stores make use of it
      s.imm        = imm;
      s.flags      = flags;
      s.set_sel    = set_sel;
      s.wr_reg     = wr_reg;
      s.wr_sel     = wr_sel;
      s.stalls     = stalls;
      steps.push_back(s);
   endtask

   task automatic build_table();
      //       kind      val/addr  imm       flags    set_sel  reg   wr_sel   stalls
      add_step(k_alu,    16'h1234, 16'h0000, 4'b0000, set_eq,  3'd1, wb_alu,  0);
      add_step(k_imm,    16'h0000, 16'hfff0, 4'b0000, set_eq,  3'd2, wb_imm,  0);
      add_step(k_set,    16'h0000, 16'h0000, 4'b1000, set_eq,  3'd3, wb_set,  0);
      add_step(k_set,    16'h0000, 16'h0000, 4'b0111, set_eq,  3'd3, wb_set,  1);
      add_step(k_set,    16'h0000, 16'h0000, 4'b0100, set_lt,  3'd4, wb_set,  0);
      add_step(k_set,    16'h0000, 16'h0000, 4'b1011, set_lt,  3'd4, wb_set,  0);
      add_step(k_set,    16'h0000, 16'h0000, 4'b1101, set_le,  3'd5, wb_set,  0);
      add_step(k_set,    16'h0000, 16'h0000, 4'b0010, set_le,  3'd5, wb_set,  0);
      add_step(k_set,    16'h0000, 16'h0000, 4'b0001, set_ofl, 3'd0, wb_set,  0);
      add_step(k_set,    16'h0000, 16'h0000, 4'b1110, set_ofl, 3'd0, wb_set,  2);
      add_step(k_store,  16'h0010, 16'h0000, 4'b0000, set_eq,  3'd0, wb_none, 2);
      add_step(k_load,   16'h0010, 16'h0000, 4'b0000, set_eq,  3'd4, wb_mem,  0);
      add_step(k_load,   16'h0033, 16'h0000, 4'b0000, set_eq,  3'd5, wb_mem,  1);
      add_step(k_bubble, 16'h0010, 16'h0000, 4'b0000, set_eq,  3'd6, wb_alu,  1);
      add_step(k_alu,    16'h5a5a, 16'h0000, 4'b0000, set_eq,  3'd6, wb_none, 0);
      add_step(k_load,   16'h0010, 16'h0000, 4'b0000, set_eq,  3'd2, wb_mem,  0);  // untouched by bubble
      add_step(k_store,  16'h0110, 16'h0000, 4'b0000, set_eq,  3'd0, wb_none, 3);  // aliases 0x10
      add_step(k_alu,    16'h00ff, 16'h0000, 4'b0000, set_eq,  3'd7, wb_alu,  0);
      add_step(k_load,   16'h0010, 16'h0000, 4'b0000, set_eq,  3'd6, wb_mem,  0);
      add_step(k_imm,    16'h0000, 16'h8001, 4'b0000, set_eq,  3'd7, wb_imm,  2);
   endtask

   // a bubble carries live-looking memory controls that must be dropped
   task automatic drive_step(input step_t s, input bit hold);
      in_alu_out      = s.val;
      in_rd_data_2    = s.store_data;
      in_sext_imm     = s.imm;
      in_alu_zero     = s.flags[3];
      in_alu_ltz      = s.flags[2];
      in_alu_lteq     = s.flags[1];
      in_alu_ofl      = s.flags[0];
      in_set_sel      = s.set_sel;
      in_mem_en       = (s.kind == k_load) || (s.kind == k_store) || (s.kind == k_bubble);
      in_mem_wr_en    = (s.kind == k_store) || (s.kind == k_bubble);
      in_wr_reg       = s.wr_reg;
      in_wr_sel       = s.wr_sel;
      in_stall_n      = (s.kind != k_bubble);
      control_stall_n = !hold;
   endtask

   function automatic bit writes_back(input step_t s);
      return (s.kind != k_bubble) && (s.wr_sel != wb_none);
   endfunction

   function automatic logic [data_w-1:0] expected_data(input step_t s);
      logic b;
      case (s.set_sel)
         set_eq:  b = s.flags[3];
         set_lt:  b = s.flags[2];
         set_le:  b = s.flags[1];
         default: b = s.flags[0];
      endcase
      case (s.kind)
         k_alu:   return s.val;
         k_imm:   return s.imm;
         k_set:   return {{(data_w-1){1'b0}}, b};
         k_load:  return model_mem[s.val[mem_addr_w-1:0]];
         default: return '0;
      endcase
   endfunction

   initial begin
      step_t s;
      int    busy;
      int    missing;
      void'($urandom(16));
      rst_n           = 1'b0;
      control_stall_n = 1'b1;
      in_stall_n      = 1'b0;
      in_alu_out      = '0;
      in_rd_data_2    = '0;
      in_sext_imm     = '0;
      in_alu_zero     = 1'b0;
      in_alu_ltz      = 1'b0;
      in_alu_lteq     = 1'b0;
      in_alu_ofl      = 1'b0;
      in_set_sel      = '0;
      in_mem_en       = 1'b0;
      in_mem_wr_en    = 1'b0;
      in_wr_reg       = '0;
      in_wr_sel       = wb_none;
      foreach (model_mem[i]) model_mem[i] = '0;   // memory is cleared by reset

      build_table();
      foreach (steps[i]) if (steps[i].stalls > max_stalls) max_stalls = steps[i].stalls;
      limit_ns    = steps.size() * (mem_latency + 2 + max_stalls) * clk_period
                    + 20 * clk_period;
      table_ready = 1'b1;

      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;

      foreach (steps[i]) begin
         s = steps[i];
         repeat (s.stalls) begin          // entry waits behind an external hold
            drive_step(s, 1'b1);
            @(posedge clk);
            #1;
         end
         drive_step(s, 1'b0);
         @(negedge clk);                  // stall_n has settled by the falling edge
         while (!stall_n) begin
            @(negedge clk);
         end
         if (writes_back(s)) chk.expect_wb(s.wr_reg, expected_data(s));
         if (s.kind == k_store) model_mem[s.val[mem_addr_w-1:0]] = s.store_data;
         @(posedge clk);                  // entry is taken here
         #1;
         if (s.kind == k_load || s.kind == k_store) begin
            busy = 0;
            while (!stall_n) begin
               busy++;
               @(posedge clk);
               #1;
            end
            if (busy != mem_latency + 1) begin
               timing_errors++;
               $display("mismatch at %0t ns: memory access held the stage %0d cycles, expected %0d",
                        $time, busy, mem_latency + 1);
            end
         end
      end

      in_stall_n = 1'b0;
      repeat (4) @(posedge clk);

      missing = chk.pending();
      if (missing != 0) $display("%0d expected writebacks never appeared on the port", missing);
      $display("errors: %0d mismatched, %0d unexpected, %0d missing, %0d stall timing",
               chk.mismatch_count, chk.unexpected_count, missing, timing_errors);
      if (chk.mismatch_count + chk.unexpected_count + missing + timing_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // watchdog sized from the table length
   initial begin
      wait (table_ready);
      #(limit_ns);
      $display("timeout: the run did not complete within %0d ns", limit_ns);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire
